//--- mini_soc.f
soc_pkg.sv
system_bus.sv
ram_memory.sv
uart.sv
mini_soc.sv
mini_soc_tb.sv

//--- mini_soc.sv
// Bus subsystem without a core; the manager port is driven from outside.
// RAM at 0x0000_0000 (1 KiB), UART at 0x8000_0000 (8 bytes).

`timescale 1ns/100ps

module mini_soc
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  input  logic     uart_rx,
  output logic     uart_tx,
  output logic     uart_irq
);

  // System bus to managed devices
  bus_req_t device_req [num_devices];
  bus_rsp_t device_rsp [num_devices];

  // --------------------------------------------------------------------
  // Interconnect
  // --------------------------------------------------------------------

  system_bus system_bus_instance (
    .clock       (clock      ),
    .reset       (reset      ),
    .manager_req (bus_req    ),
    .manager_rsp (bus_rsp    ),
    .device_req  (device_req ),
    .device_rsp  (device_rsp )
  );

  // --------------------------------------------------------------------
  // Managed devices
  // --------------------------------------------------------------------

  ram_memory ram_instance (
    .clock (clock               ),
    .reset (reset               ),
    .req   (device_req[dev_ram] ),
    .rsp   (device_rsp[dev_ram] )
  );

  uart uart_instance (
    .clock    (clock                ),
    .reset    (reset                ),
    .req      (device_req[dev_uart] ),
    .rsp      (device_rsp[dev_uart] ),
    .uart_rx  (uart_rx              ),
    .uart_tx  (uart_tx              ),
    .uart_irq (uart_irq             )
  );

endmodule

//--- mini_soc_stim.txt
# Columns (hex): op address write_data strobe expected_read
# op 1 write 1-cycle, 2 read 1-cycle, 3 write stalled, 4 wait irq then read, 5 write any latency
1 00000000 12345678 f 00000000
1 00000004 cafef00d f 00000000
1 000003fc a5a55a5a f 00000000
2 00000000 00000000 0 12345678
2 00000004 00000000 0 cafef00d
2 000003fc 00000000 0 a5a55a5a
1 00000010 ffffffff f 00000000
1 00000010 11223344 5 00000000
2 00000010 00000000 0 ff22ff44
2 40000000 00000000 0 00000000
2 80000008 00000000 0 00000000
1 40000000 deadbeef f 00000000
1 80000008 deadbeef f 00000000
2 00000000 00000000 0 12345678
1 80000000 000000a5 f 00000000
4 80000000 00000000 0 000000a5
5 80000000 0000003c f 00000000
3 80000000 000000c3 f 00000000
4 80000000 00000000 0 0000003c
4 80000000 00000000 0 000000c3

//--- mini_soc_tb.sv
// Plays the bus manager by replaying mini_soc_stim.txt, run from the project root.
// UART output is looped back to its input, so every sent byte is received again.

`timescale 1ns/100ps

module mini_soc_tb
  import soc_pkg::*;
();

  // One stim line
  typedef struct packed {
    logic [7:0]  code;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [3:0]  strobe;
    logic [31:0] expected;
  } stim_op_t;

  localparam int clock_period_ns = 4;
  localparam int frame_cycles    = 10 * cycles_per_bit;
  localparam int response_limit  = 4 * frame_cycles;

  // Operation codes used in the stim file
  localparam logic [7:0] op_write       = 8'h1;
  localparam logic [7:0] op_read        = 8'h2;
  localparam logic [7:0] op_write_stall = 8'h3;
  localparam logic [7:0] op_irq_read    = 8'h4;
  localparam logic [7:0] op_write_any   = 8'h5;

  logic     clock;
  logic     reset;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     uart_irq;
  wire      uart_line;

  stim_op_t ops [$];
  int       error_count;
  int       failed_tests;
  int       test_count;
  bit       ops_loaded;

  mini_soc u_mini_soc (
    .clock    (clock    ),
    .reset    (reset    ),
    .bus_req  (bus_req  ),
    .bus_rsp  (bus_rsp  ),
    .uart_rx  (uart_line),
    .uart_tx  (uart_line),
    .uart_irq (uart_irq )
  );

  always #(clock_period_ns / 2) clock = ~clock;

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  task automatic report_mismatch(input string name, input string expected,
                                 input string actual);
    $display("CHECK FAILED at %0t ns: %s expected %s, got %s", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic load_stim();
    int          fd;
    int          line_no;
    int          fields;
    string       line;
    logic [7:0]  code;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [3:0]  strobe;
    logic [31:0] expected;
    stim_op_t    op;
    fd = $fopen("mini_soc_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open mini_soc_stim.txt for reading");
      error_count++;
    end else begin
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
        line_no++;
        // Skip comments and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%h %h %h %h %h", code, address, write_data, strobe,
                           expected);
          if (fields != 5) begin
            $display("Stim line %0d is malformed, found %0d fields", line_no, fields);
            error_count++;
          end else begin
            op.code       = code;
            op.address    = address;
            op.write_data = write_data;
            op.strobe     = strobe;
            op.expected   = expected;
            ops.push_back(op);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Request on a falling edge, then count falling edges until the response
  task automatic bus_access(input bit is_read, input stim_op_t op, output int latency,
                            output logic [31:0] data, output bit answered);
    latency  = 0;
    data     = '0;
    answered = 1'b0;
    @(negedge clock);
    bus_req.rw_address    = op.address;
    bus_req.write_data    = op.write_data;
    bus_req.write_strobe  = op.strobe;
    bus_req.read_request  = is_read;
    bus_req.write_request = !is_read;
    while (!answered && latency < response_limit) begin
      @(negedge clock);
      bus_req.read_request  = 1'b0;
      bus_req.write_request = 1'b0;
      latency++;
      if (is_read ? bus_rsp.read_response : bus_rsp.write_response) begin
        answered = 1'b1;
        data     = bus_rsp.read_data;
      end
    end
  endtask

  task automatic wait_irq(output bit seen);
    int waited;
    waited = 0;
    seen   = uart_irq;
    while (!seen && waited < response_limit) begin
      @(negedge clock);
      waited++;
      seen = uart_irq;
    end
  endtask

  task automatic run_op(input int index, input stim_op_t op);
    int          latency;
    logic [31:0] data;
    bit          answered;
    bit          seen;
    int          errors_before;
    errors_before = error_count;
    case (op.code)
      op_write, op_write_stall, op_write_any: begin
        bus_access(1'b0, op, latency, data, answered);
        if (!answered) begin
          $display("Write to 0x%08h got no write_response within %0d cycles",
                   op.address, response_limit);
          error_count++;
        end else if (op.code == op_write && latency != 1) begin
          report_mismatch("write_response latency", "1", $sformatf("%0d", latency));
        end else if (op.code == op_write_stall && latency <= 1) begin
          report_mismatch("write_response latency", "more than 1", $sformatf("%0d", latency));
        end
      end
      op_read, op_irq_read: begin
        seen = 1'b1;
        if (op.code == op_irq_read) begin
          wait_irq(seen);
          if (!seen) begin
            $display("uart_irq never rose within %0d cycles", response_limit);
            error_count++;
          end
        end
        if (seen) begin
          bus_access(1'b1, op, latency, data, answered);
          if (!answered) begin
            $display("Read from 0x%08h got no read_response within %0d cycles",
                     op.address, response_limit);
            error_count++;
          end else begin
            if (latency != 1) begin
              report_mismatch("read_response latency", "1", $sformatf("%0d", latency));
            end
            if (data !== op.expected) begin
              report_mismatch("bus_rsp.read_data", $sformatf("0x%08h", op.expected),
                              $sformatf("0x%08h", data));
            end
            // Data register read clears the interrupt with the response
            if (op.code == op_irq_read && uart_irq !== 1'b0) begin
              report_mismatch("uart_irq", "0", $sformatf("%0b", uart_irq));
            end
          end
        end
      end
      default: begin
        $display("Unknown operation code %0h in stim entry %0d", op.code, index);
        error_count++;
      end
    endcase
    test_count++;
    if (error_count == errors_before) begin
      $display("Test %0d: op %0h at 0x%08h passed", index, op.code, op.address);
    end else begin
      failed_tests++;
      $display("Test %0d: op %0h at 0x%08h failed", index, op.code, op.address);
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------

  initial begin : main
    int errors_before;
    clock        = 1'b0;
    reset        = 1'b1;
    bus_req      = '0;
    error_count  = 0;
    failed_tests = 0;
    test_count   = 0;
    ops_loaded   = 1'b0;
    load_stim();
    ops_loaded = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // Idle outputs before any request
    errors_before = error_count;
    if (bus_rsp.read_response !== 1'b0) begin
      report_mismatch("bus_rsp.read_response", "0", $sformatf("%0b", bus_rsp.read_response));
    end
    if (bus_rsp.write_response !== 1'b0) begin
      report_mismatch("bus_rsp.write_response", "0", $sformatf("%0b", bus_rsp.write_response));
    end
    if (uart_irq !== 1'b0) begin
      report_mismatch("uart_irq", "0", $sformatf("%0b", uart_irq));
    end
    if (uart_line !== 1'b1) begin
      report_mismatch("uart_tx", "1", $sformatf("%0b", uart_line));
    end
    test_count++;
    if (error_count == errors_before) begin
      $display("Test 0: reset state passed");
    end else begin
      failed_tests++;
      $display("Test 0: reset state failed");
    end

    for (int i = 0; i < ops.size(); i++) begin
      run_op(i + 1, ops[i]);
    end

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Budget of two UART frames per stim line
  initial begin : watchdog
    int limit_ns;
    wait (ops_loaded);
    limit_ns = (ops.size() + 1) * 2 * frame_cycles * clock_period_ns + 2000;
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- ram_memory.sv
// Word-organized RAM, contents undefined after power-up.
// Only address bits below ram_size are decoded; upper bits are ignored.

`timescale 1ns/100ps

module ram_memory
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  bus_req_t req,
  output bus_rsp_t rsp
);

  logic [31:0]                     mem [ram_size/4];
  logic [$clog2(ram_size/4)-1:0]   word_index;
  logic [31:0]                     read_data_q;
  logic                            read_response_q;
  logic                            write_response_q;

  // Drop the byte offset
  assign word_index = req.rw_address[$clog2(ram_size)-1:2];

  // Byte-strobed write and registered read
  always_ff @(posedge clock) begin
    if (req.write_request) begin
      for (int b = 0; b < 4; b++) begin
        if (req.write_strobe[b]) begin
          mem[word_index][8*b +: 8] <= req.write_data[8*b +: 8];
        end
      end
    end
    if (req.read_request) begin
      read_data_q <= mem[word_index];
    end
  end

  // Response pulses one cycle after the request
  always_ff @(posedge clock) begin
    if (reset) begin
      read_response_q  <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      read_response_q  <= req.read_request;
      write_response_q <= req.write_request;
    end
  end

  assign rsp.read_data      = read_data_q;
  assign rsp.read_response  = read_response_q;
  assign rsp.write_response = write_response_q;

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f mini_soc.f --top-module mini_soc_tb \
       -o mini_soc_sim \
  && ./obj_dir/mini_soc_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
exit 0

//--- soc_pkg.sv
// Address map, bus structs and UART timing shared by the whole subsystem.
// The bit period is fixed at elaboration, so baud rate changes need a rebuild.

package soc_pkg;

  // --------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------

  localparam int num_devices = 2;
  localparam int dev_ram     = 0;
  localparam int dev_uart    = 1;

  localparam logic [31:0] ram_base  = 32'h0000_0000;
  localparam logic [31:0] ram_size  = 32'd1024;
  localparam logic [31:0] uart_base = 32'h8000_0000;
  localparam logic [31:0] uart_size = 32'd8;

  // Clocks per serial bit, kept short for simulation
  localparam int cycles_per_bit = 8;

  // --------------------------------------------------------------------
  // Bus payloads
  // --------------------------------------------------------------------

  // Request pulses last one cycle, other fields valid alongside
  typedef struct packed {
    logic [31:0] rw_address;
    logic [31:0] write_data;
    logic [3:0]  write_strobe;
    logic        read_request;
    logic        write_request;
  } bus_req_t;

  // read_data is valid with read_response
  typedef struct packed {
    logic [31:0] read_data;
    logic        read_response;
    logic        write_response;
  } bus_rsp_t;

endpackage

//--- system_bus.sv
// One outstanding request at a time; the manager waits for each response.
// Unmapped addresses answer after one cycle with zero read data, writes dropped.

`timescale 1ns/100ps

module system_bus
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  bus_req_t manager_req,
  output bus_rsp_t manager_rsp,
  output bus_req_t device_req [num_devices],
  input  bus_rsp_t device_rsp [num_devices]
);

  logic [num_devices-1:0]         hit;
  logic [num_devices-1:0]         dev_pulse;
  logic [$clog2(num_devices)-1:0] hit_index;
  logic [$clog2(num_devices)-1:0] sel_q;
  logic                           mapped;
  logic                           req_any;
  logic                           unmapped_q;
  logic                           unmapped_rd_q;
  logic                           unmapped_wr_q;

  // --------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------

  // Offset compare keeps the base <= addr < base + size check in 32 bits
  assign hit[dev_ram]  = (manager_req.rw_address - ram_base) < ram_size;
  assign hit[dev_uart] = (manager_req.rw_address - uart_base) < uart_size;

  assign mapped  = |hit;
  assign req_any = manager_req.read_request | manager_req.write_request;

  always_comb begin
    hit_index = '0;
    for (int i = 0; i < num_devices; i++) begin
      if (hit[i]) begin
        hit_index = i[$clog2(num_devices)-1:0];
      end
    end
  end

  // Address and data fan out to all devices, pulses only to the hit one
  always_comb begin
    for (int i = 0; i < num_devices; i++) begin
      device_req[i]               = manager_req;
      device_req[i].read_request  = manager_req.read_request & hit[i];
      device_req[i].write_request = manager_req.write_request & hit[i];
      dev_pulse[i]                = device_req[i].read_request |
                                    device_req[i].write_request;
    end
  end

  // --------------------------------------------------------------------
  // Response steering
  // --------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q         <= '0;
      unmapped_q    <= 1'b0;
      unmapped_rd_q <= 1'b0;
      unmapped_wr_q <= 1'b0;
    end else begin
      unmapped_rd_q <= manager_req.read_request & ~mapped;
      unmapped_wr_q <= manager_req.write_request & ~mapped;
      // Select holds until the next request, covering slow UART writes
      if (req_any) begin
        sel_q      <= hit_index;
        unmapped_q <= ~mapped;
      end
    end
  end

  always_comb begin
    if (unmapped_q) begin
      manager_rsp.read_data      = '0;
      manager_rsp.read_response  = unmapped_rd_q;
      manager_rsp.write_response = unmapped_wr_q;
    end else begin
      manager_rsp = device_rsp[sel_q];
    end
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------

  // At most one device sees a request in any cycle
  assert property (@(posedge clock) disable iff (reset)
    $onehot0(dev_pulse));

  // Manager must not read and write at once
  assert property (@(posedge clock) disable iff (reset)
    !(manager_req.read_request && manager_req.write_request));

endmodule

//--- uart.sv
// 8N1 UART with one data register; any write offset sends a byte.
// Reads at offset 0 return the last received byte, other offsets read 0.

`timescale 1ns/100ps

module uart
  import soc_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  bus_req_t req,
  output bus_rsp_t rsp,
  input  logic     uart_rx,
  output logic     uart_tx,
  output logic     uart_irq
);

  logic [$clog2(cycles_per_bit)-1:0] tx_tick_cnt;
  logic [3:0]                        tx_bit_cnt;
  logic [9:0]                        tx_shift;
  logic                              tx_busy;
  logic                              pending_q;
  logic [7:0]                        pending_data_q;
  logic                              tx_accept;
  logic [7:0]                        tx_byte;

  logic [2:0]                        rx_sync;
  logic [$clog2(cycles_per_bit)-1:0] rx_tick_cnt;
  logic [3:0]                        rx_bit_cnt;
  logic [7:0]                        rx_shift;
  logic [7:0]                        rx_data;
  logic                              rx_busy;
  logic                              rx_mid;
  logic                              read_data_reg;

  logic [31:0]                       read_data_q;
  logic                              read_response_q;
  logic                              write_response_q;

  // --------------------------------------------------------------------
  // Transmitter
  // --------------------------------------------------------------------

  // A write waits here while a frame is still going out
  assign tx_accept = (req.write_request | pending_q) & ~tx_busy;
  assign tx_byte   = pending_q ? pending_data_q : req.write_data[7:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      tx_busy          <= 1'b0;
      tx_shift         <= '1;
      tx_tick_cnt      <= '0;
      tx_bit_cnt       <= '0;
      pending_q        <= 1'b0;
      write_response_q <= 1'b0;
    end else begin
      write_response_q <= tx_accept;
      if (tx_accept) begin
        // Stop bit, data LSB first, start bit
        tx_shift    <= {1'b1, tx_byte, 1'b0};
        tx_busy     <= 1'b1;
        tx_tick_cnt <= '0;
        tx_bit_cnt  <= '0;
        pending_q   <= 1'b0;
      end else begin
        if (req.write_request) begin
          pending_q <= 1'b1;
        end
        if (tx_busy) begin
          if (tx_tick_cnt == cycles_per_bit - 1) begin
            tx_tick_cnt <= '0;
            tx_shift    <= {1'b1, tx_shift[9:1]};
            tx_bit_cnt  <= tx_bit_cnt + 4'd1;
            if (tx_bit_cnt == 4'd9) begin
              tx_busy <= 1'b0;
            end
          end else begin
            tx_tick_cnt <= tx_tick_cnt + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.write_request & ~tx_accept) begin
      pending_data_q <= req.write_data[7:0];
    end
  end

  // Shifter refills with ones, so the line idles high
  assign uart_tx = tx_shift[0];

  // --------------------------------------------------------------------
  // Receiver
  // --------------------------------------------------------------------

  assign rx_mid = rx_busy && (rx_tick_cnt == cycles_per_bit/2 - 1);

  always_ff @(posedge clock) begin
    if (reset) begin
      rx_sync     <= '1;
      rx_busy     <= 1'b0;
      rx_tick_cnt <= '0;
      rx_bit_cnt  <= '0;
      uart_irq    <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[1:0], uart_rx};
      // Clear on data register read, new byte wins
      if (req.read_request && read_data_reg) begin
        uart_irq <= 1'b0;
      end
      if (!rx_busy) begin
        if (rx_sync[2] && !rx_sync[1]) begin
          rx_busy     <= 1'b1;
          rx_tick_cnt <= '0;
          rx_bit_cnt  <= '0;
        end
      end else begin
        if (rx_tick_cnt == cycles_per_bit - 1) begin
          rx_tick_cnt <= '0;
        end else begin
          rx_tick_cnt <= rx_tick_cnt + 1'b1;
        end
        if (rx_mid) begin
          rx_bit_cnt <= rx_bit_cnt + 4'd1;
          // False start, line back high at mid start bit
          if (rx_bit_cnt == 4'd0 && rx_sync[1]) begin
            rx_busy <= 1'b0;
          end
          if (rx_bit_cnt == 4'd9) begin
            rx_busy <= 1'b0;
            if (rx_sync[1]) begin
              uart_irq <= 1'b1;
            end
          end
        end
      end
    end
  end

  // Data bits shift in from the top
  always_ff @(posedge clock) begin
    if (rx_mid && rx_bit_cnt >= 4'd1 && rx_bit_cnt <= 4'd8) begin
      rx_shift <= {rx_sync[1], rx_shift[7:1]};
    end
    if (rx_mid && rx_bit_cnt == 4'd9 && rx_sync[1]) begin
      rx_data <= rx_shift;
    end
  end

  // --------------------------------------------------------------------
  // Register read
  // --------------------------------------------------------------------

  assign read_data_reg = (req.rw_address[2:0] == 3'd0);

  always_ff @(posedge clock) begin
    if (req.read_request) begin
      read_data_q <= read_data_reg ? {24'd0, rx_data} : 32'd0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      read_response_q <= 1'b0;
    end else begin
      read_response_q <= req.read_request;
    end
  end

  assign rsp.read_data      = read_data_q;
  assign rsp.read_response  = read_response_q;
  assign rsp.write_response = write_response_q;

  // Line must idle high between frames
  assert property (@(posedge clock) disable iff (reset)
    !tx_busy |-> uart_tx);

endmodule
